/* list.f */
design/axil_pkg.sv
design/soc_cfg_pkg.sv
design/axil_if.sv
design/axil_decoder.sv
design/axil_sram.sv
design/axil_bootrom.sv
design/debug_req_gate.sv
design/soc_top.sv
test/tb_soc_top.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_soc_top
RTL_TOP    ?= soc_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := Checks failed
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_soc_top.sv */
// Testbench for the memory-mapped subsystem
// Directed tests for boot ROM, SRAM, decode errors, back-pressure on the
// response channels and the debug request gate

`timescale 1ns/1ps

module tb_soc_top;

  localparam int DebugDelay  = 20;
  localparam int SramBytes   = 1024 * 4;
  localparam int MaxWait     = 100;
  localparam int StallCycles = 6;

  logic            clk_i;
  logic            rst_ni;
  axil_pkg::addr_t s_awaddr_i;
  logic            s_awvalid_i;
  logic            s_awready_o;
  axil_pkg::data_t s_wdata_i;
  axil_pkg::strb_t s_wstrb_i;
  logic            s_wvalid_i;
  logic            s_wready_o;
  axil_pkg::resp_e s_bresp_o;
  logic            s_bvalid_o;
  logic            s_bready_i;
  axil_pkg::addr_t s_araddr_i;
  logic            s_arvalid_i;
  logic            s_arready_o;
  axil_pkg::data_t s_rdata_o;
  axil_pkg::resp_e s_rresp_o;
  logic            s_rvalid_o;
  logic            s_rready_i;
  logic            debug_req_i;
  logic            debug_enable_i;
  logic            debug_req_o;

  logic [31:0]     lfsr_q;
  int              data_errs;
  int              resp_errs;
  int              bit_errs;
  // Expected SRAM contents at the offsets below
  axil_pkg::data_t sram_model [5];
  axil_pkg::addr_t sram_offs [5];

  soc_top #(
    .DebugDelayCycles ( DebugDelay )
  ) u_dut (
    .clk_i, .rst_ni,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o,
    .s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
    .s_bresp_o, .s_bvalid_o, .s_bready_i,
    .s_araddr_i, .s_arvalid_i, .s_arready_o,
    .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .debug_req_i, .debug_enable_i, .debug_req_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Random words and reference helpers
  // --------------------------------------------------------------------------
  // Taps of x^32 + x^22 + x^2 + x + 1 with one step per bit
  function automatic axil_pkg::data_t random_word();
    axil_pkg::data_t w;
    logic            fb;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      w      = {w[30:0], fb};
    end
    return w;
  endfunction

  function automatic axil_pkg::data_t merge_bytes(input axil_pkg::data_t old_w,
                                                  input axil_pkg::data_t new_w,
                                                  input axil_pkg::strb_t strb);
    axil_pkg::data_t m;
    m = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) m[8*b +: 8] = new_w[8*b +: 8];
    end
    return m;
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks and run control
  // --------------------------------------------------------------------------
  task automatic check_data(input string name, input axil_pkg::data_t got,
                            input axil_pkg::data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("ERR %0d ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axil_pkg::resp_e got,
                            input axil_pkg::resp_e exp);
    if (got !== exp) begin
      resp_errs++;
      $display("ERR %0d ns %s got %s (%b) expected %s", $time, name, got.name(), got,
               exp.name());
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("ERR %0d ns %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic print_counts();
    $display("Errors: data %0d, resp %0d, bit %0d", data_errs, resp_errs, bit_errs);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out at %0d ns waiting for %s", $time, what);
    print_counts();
    $display("Checks failed");
    $finish;
  endtask

  // --------------------------------------------------------------------------
  // Bus waits that end one drive slot after the handshake edge or at the
  // falling edge where the response is seen
  // --------------------------------------------------------------------------
  task automatic wait_write_accept();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!(s_awready_o && s_wready_o) && n < MaxWait) begin
      @(negedge clk_i);
      n++;
    end
    if (!(s_awready_o && s_wready_o)) begin
      stop_on_timeout("awready and wready");
    end else begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wait_read_accept();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!s_arready_o && n < MaxWait) begin
      @(negedge clk_i);
      n++;
    end
    if (!s_arready_o) begin
      stop_on_timeout("arready");
    end else begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wait_bvalid();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!s_bvalid_o && n < MaxWait) begin
      @(negedge clk_i);
      n++;
    end
    if (!s_bvalid_o) stop_on_timeout("bvalid");
  endtask

  task automatic wait_rvalid();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!s_rvalid_o && n < MaxWait) begin
      @(negedge clk_i);
      n++;
    end
    if (!s_rvalid_o) stop_on_timeout("rvalid");
  endtask

  task automatic axil_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                            input axil_pkg::strb_t strb, output axil_pkg::resp_e resp);
    @(posedge clk_i);
    #1;
    s_awaddr_i  = addr;
    s_awvalid_i = 1'b1;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_wvalid_i  = 1'b1;
    s_bready_i  = 1'b1;
    wait_write_accept();
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    wait_bvalid();
    resp = s_bresp_o;
    @(posedge clk_i);
    #1;
    s_bready_i = 1'b0;
  endtask

  task automatic axil_read(input axil_pkg::addr_t addr, output axil_pkg::data_t data,
                           output axil_pkg::resp_e resp);
    @(posedge clk_i);
    #1;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    s_rready_i  = 1'b1;
    wait_read_accept();
    s_arvalid_i = 1'b0;
    wait_rvalid();
    data = s_rdata_o;
    resp = s_rresp_o;
    @(posedge clk_i);
    #1;
    s_rready_i = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic check_idle_outputs();
    check_bit("s_awready_o", s_awready_o, 1'b0);
    check_bit("s_wready_o", s_wready_o, 1'b0);
    check_bit("s_arready_o", s_arready_o, 1'b0);
    check_bit("s_bvalid_o", s_bvalid_o, 1'b0);
    check_bit("s_rvalid_o", s_rvalid_o, 1'b0);
  endtask

  // Starts right at reset release with k counting rising edges since then
  task automatic test_debug_gate();
    for (int k = 0; k <= DebugDelay; k++) begin
      @(negedge clk_i);
      check_bit("debug_req_o", debug_req_o, (k == DebugDelay));
    end
    @(posedge clk_i);
    #1;
    debug_enable_i = 1'b0;
    repeat (5) begin
      @(negedge clk_i);
      check_bit("debug_req_o", debug_req_o, 1'b0);
    end
  endtask

  task automatic test_rom_read();
    axil_pkg::data_t d;
    axil_pkg::resp_e r;
    for (int i = 0; i < soc_cfg_pkg::RomWords; i++) begin
      axil_read(soc_cfg_pkg::RomBase + 32'(4 * i), d, r);
      check_data("s_rdata_o", d, soc_cfg_pkg::BootRomImage[i]);
      check_resp("s_rresp_o", r, axil_pkg::RESP_OKAY);
    end
    // Past the image but still inside the window
    axil_read(soc_cfg_pkg::RomBase + 32'h20, d, r);
    check_data("s_rdata_o", d, '0);
    check_resp("s_rresp_o", r, axil_pkg::RESP_OKAY);
    axil_read(soc_cfg_pkg::RomBase + soc_cfg_pkg::RomLength - 32'h4, d, r);
    check_data("s_rdata_o", d, '0);
    check_resp("s_rresp_o", r, axil_pkg::RESP_OKAY);
  endtask

  task automatic test_rom_write();
    axil_pkg::data_t d;
    axil_pkg::resp_e r;
    axil_write(soc_cfg_pkg::RomBase + 32'h8, 32'hdead_beef, 4'hf, r);
    check_resp("s_bresp_o", r, axil_pkg::RESP_SLVERR);
    axil_read(soc_cfg_pkg::RomBase + 32'h8, d, r);
    check_data("s_rdata_o", d, soc_cfg_pkg::BootRomImage[2]);
    check_resp("s_rresp_o", r, axil_pkg::RESP_OKAY);
  endtask

  task automatic test_sram();
    axil_pkg::data_t d;
    axil_pkg::data_t nw;
    axil_pkg::resp_e r;
    axil_pkg::strb_t strbs [3];
    sram_offs[0] = 32'h0;
    sram_offs[1] = 32'h4;
    sram_offs[2] = 32'h10;
    sram_offs[3] = 32'h200;
    sram_offs[4] = 32'(SramBytes - 4);
    strbs[0] = 4'b0001;
    strbs[1] = 4'b0110;
    strbs[2] = 4'b1000;
    for (int i = 0; i < 5; i++) begin
      sram_model[i] = random_word();
      axil_write(soc_cfg_pkg::SramBase + sram_offs[i], sram_model[i], 4'hf, r);
      check_resp("s_bresp_o", r, axil_pkg::RESP_OKAY);
    end
    for (int i = 0; i < 5; i++) begin
      axil_read(soc_cfg_pkg::SramBase + sram_offs[i], d, r);
      check_data("s_rdata_o", d, sram_model[i]);
      check_resp("s_rresp_o", r, axil_pkg::RESP_OKAY);
    end
    // Partial writes keep the unselected bytes
    for (int j = 0; j < 3; j++) begin
      nw = random_word();
      axil_write(soc_cfg_pkg::SramBase + sram_offs[j+1], nw, strbs[j], r);
      check_resp("s_bresp_o", r, axil_pkg::RESP_OKAY);
      sram_model[j+1] = merge_bytes(sram_model[j+1], nw, strbs[j]);
      axil_read(soc_cfg_pkg::SramBase + sram_offs[j+1], d, r);
      check_data("s_rdata_o", d, sram_model[j+1]);
    end
  endtask

  task automatic test_decode_error();
    axil_pkg::addr_t bad [3];
    axil_pkg::data_t d;
    axil_pkg::resp_e r;
    bad[0] = 32'h4000_0000;
    bad[1] = soc_cfg_pkg::RomBase + soc_cfg_pkg::RomLength;
    bad[2] = soc_cfg_pkg::SramBase + 32'(SramBytes);
    for (int i = 0; i < 3; i++) begin
      axil_read(bad[i], d, r);
      check_data("s_rdata_o", d, '0);
      check_resp("s_rresp_o", r, axil_pkg::RESP_DECERR);
      axil_write(bad[i], 32'h1234_5678, 4'hf, r);
      check_resp("s_bresp_o", r, axil_pkg::RESP_DECERR);
    end
  endtask

  // R stalls with a write pending and then B stalls with a read pending
  task automatic test_back_pressure();
    axil_pkg::data_t wd;
    axil_pkg::data_t d0;
    axil_pkg::resp_e r0;
    wd = random_word();
    @(posedge clk_i);
    #1;
    s_araddr_i  = soc_cfg_pkg::SramBase;
    s_arvalid_i = 1'b1;
    s_rready_i  = 1'b0;
    wait_read_accept();
    s_arvalid_i = 1'b0;
    wait_rvalid();
    d0 = s_rdata_o;
    r0 = s_rresp_o;
    check_data("s_rdata_o", d0, sram_model[0]);
    check_resp("s_rresp_o", r0, axil_pkg::RESP_OKAY);
    @(posedge clk_i);
    #1;
    s_awaddr_i  = soc_cfg_pkg::SramBase + 32'h40;
    s_wdata_i   = wd;
    s_wstrb_i   = 4'hf;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    s_bready_i  = 1'b0;
    repeat (StallCycles) begin
      @(negedge clk_i);
      check_bit("s_rvalid_o", s_rvalid_o, 1'b1);
      check_data("s_rdata_o", s_rdata_o, d0);
      check_resp("s_rresp_o", s_rresp_o, r0);
      check_bit("s_awready_o", s_awready_o, 1'b0);
    end
    @(posedge clk_i);
    #1;
    s_rready_i = 1'b1;
    wait_write_accept();
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    s_rready_i  = 1'b0;
    wait_bvalid();
    r0 = s_bresp_o;
    check_resp("s_bresp_o", r0, axil_pkg::RESP_OKAY);
    @(posedge clk_i);
    #1;
    s_araddr_i  = soc_cfg_pkg::SramBase + 32'h40;
    s_arvalid_i = 1'b1;
    s_rready_i  = 1'b1;
    repeat (StallCycles) begin
      @(negedge clk_i);
      check_bit("s_bvalid_o", s_bvalid_o, 1'b1);
      check_resp("s_bresp_o", s_bresp_o, r0);
      check_bit("s_arready_o", s_arready_o, 1'b0);
    end
    @(posedge clk_i);
    #1;
    s_bready_i = 1'b1;
    wait_read_accept();
    s_arvalid_i = 1'b0;
    s_bready_i  = 1'b0;
    wait_rvalid();
    check_data("s_rdata_o", s_rdata_o, wd);
    @(posedge clk_i);
    #1;
    s_rready_i = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    lfsr_q         = 32'h7626;
    data_errs      = 0;
    resp_errs      = 0;
    bit_errs       = 0;
    rst_ni         = 1'b0;
    s_awaddr_i     = '0;
    s_awvalid_i    = 1'b0;
    s_wdata_i      = '0;
    s_wstrb_i      = '0;
    s_wvalid_i     = 1'b0;
    s_bready_i     = 1'b0;
    s_araddr_i     = '0;
    s_arvalid_i    = 1'b0;
    s_rready_i     = 1'b0;
    debug_req_i    = 1'b1;
    debug_enable_i = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_idle_outputs();
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_debug_gate();
    test_rom_read();
    test_rom_write();
    test_sram();
    test_decode_error();
    test_back_pressure();
    print_counts();
    if (data_errs + resp_errs + bit_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* design/soc_top.sv */
// Memory-mapped subsystem top level
// One AXI4-Lite manager port reaching boot ROM and SRAM through the
// decoder, plus the gated debug request

`timescale 1ns/1ps

module soc_top #(
  parameter int unsigned SramWords        = 1024,
  parameter int unsigned DebugDelayCycles = 500
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // AW
  input  axil_pkg::addr_t s_awaddr_i,
  input  logic            s_awvalid_i,
  output logic            s_awready_o,
  // W
  input  axil_pkg::data_t s_wdata_i,
  input  axil_pkg::strb_t s_wstrb_i,
  input  logic            s_wvalid_i,
  output logic            s_wready_o,
  // B
  output axil_pkg::resp_e s_bresp_o,
  output logic            s_bvalid_o,
  input  logic            s_bready_i,
  // AR
  input  axil_pkg::addr_t s_araddr_i,
  input  logic            s_arvalid_i,
  output logic            s_arready_o,
  // R
  output axil_pkg::data_t s_rdata_o,
  output axil_pkg::resp_e s_rresp_o,
  output logic            s_rvalid_o,
  input  logic            s_rready_i,
  // Debug
  input  logic            debug_req_i,
  input  logic            debug_enable_i,
  output logic            debug_req_o
);

  axil_if mgr_bus ();
  axil_if rom_bus ();
  axil_if sram_bus ();

  // --------------------------------------------------------------------------
  // External port onto the decoder bus
  // --------------------------------------------------------------------------
  assign mgr_bus.aw_addr  = s_awaddr_i;
  assign mgr_bus.aw_valid = s_awvalid_i;
  assign s_awready_o      = mgr_bus.aw_ready;
  assign mgr_bus.w_data   = s_wdata_i;
  assign mgr_bus.w_strb   = s_wstrb_i;
  assign mgr_bus.w_valid  = s_wvalid_i;
  assign s_wready_o       = mgr_bus.w_ready;
  assign s_bresp_o        = mgr_bus.b_resp;
  assign s_bvalid_o       = mgr_bus.b_valid;
  assign mgr_bus.b_ready  = s_bready_i;
  assign mgr_bus.ar_addr  = s_araddr_i;
  assign mgr_bus.ar_valid = s_arvalid_i;
  assign s_arready_o      = mgr_bus.ar_ready;
  assign s_rdata_o        = mgr_bus.r_data;
  assign s_rresp_o        = mgr_bus.r_resp;
  assign s_rvalid_o       = mgr_bus.r_valid;
  assign mgr_bus.r_ready  = s_rready_i;

  // --------------------------------------------------------------------------
  // Bus fabric and targets
  // --------------------------------------------------------------------------
  axil_decoder #(
    .SramWords ( SramWords )
  ) i_decoder (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .mgr      ( mgr_bus  ),
    .rom_bus  ( rom_bus  ),
    .sram_bus ( sram_bus )
  );

  axil_bootrom i_bootrom (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .bus    ( rom_bus )
  );

  axil_sram #(
    .SramWords ( SramWords )
  ) i_sram (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .bus    ( sram_bus )
  );

  // Debug request hold-off
  debug_req_gate #(
    .DebugDelayCycles ( DebugDelayCycles )
  ) i_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

/* design/debug_req_gate.sv */
// Debug request gate
// Holds off debug requests for a fixed time after reset so boot code can
// run first, and masks them when debug is disabled

`timescale 1ns/1ps

module debug_req_gate #(
  parameter int unsigned DebugDelayCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth =
      (DebugDelayCycles > 0) ? $clog2(DebugDelayCycles + 1) : 1;

  typedef logic [CntWidth-1:0] delay_cnt_t;

  delay_cnt_t delay_cnt_q;

  // Counts down once per cycle and stays at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_cnt_q <= delay_cnt_t'(DebugDelayCycles);
    end else if (delay_cnt_q != '0) begin
      delay_cnt_q <= delay_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (delay_cnt_q == '0) & debug_enable_i & debug_req_i;

endmodule

/* design/axil_bootrom.sv */
// AXI4-Lite boot ROM
// Serves the fixed boot image, reads zero past its end, and answers
// every write with SLVERR

`timescale 1ns/1ps

module axil_bootrom (
  input  logic clk_i,
  input  logic rst_ni,
  axil_if.subordinate bus
);

  localparam int unsigned RomIdxWidth = $clog2(soc_cfg_pkg::RomLength / 4);
  localparam int unsigned ImgIdxWidth = $clog2(soc_cfg_pkg::RomWords);

  typedef logic [RomIdxWidth-1:0] rom_idx_t;

  axil_pkg::data_t r_data_q;
  logic            r_valid_q;
  logic            b_valid_q;
  rom_idx_t        rd_idx;
  logic            rd_hs, wr_hs;

  // One request at a time, reads first
  assign bus.ar_ready = bus.ar_valid & ~(r_valid_q | b_valid_q);
  assign bus.aw_ready = bus.aw_valid & bus.w_valid & ~bus.ar_valid & ~(r_valid_q | b_valid_q);
  assign bus.w_ready  = bus.aw_ready;

  assign rd_hs  = bus.ar_valid & bus.ar_ready;
  assign wr_hs  = bus.aw_valid & bus.aw_ready;
  assign rd_idx = bus.ar_addr[RomIdxWidth+1:2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (bus.r_ready) begin
        r_valid_q <= 1'b0;
      end
      // Write data is dropped, only the error goes back
      if (wr_hs) begin
        b_valid_q <= 1'b1;
      end else if (bus.b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // Image lookup, zero above the last initialised word
  always_ff @(posedge clk_i) begin
    if (rd_hs) begin
      if (rd_idx < rom_idx_t'(soc_cfg_pkg::RomWords)) begin
        r_data_q <= soc_cfg_pkg::BootRomImage[rd_idx[ImgIdxWidth-1:0]];
      end else begin
        r_data_q <= '0;
      end
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_data  = r_data_q;
  assign bus.r_resp  = axil_pkg::RESP_OKAY;
  assign bus.b_valid = b_valid_q;
  assign bus.b_resp  = axil_pkg::RESP_SLVERR;

endmodule

/* design/axil_sram.sv */
// AXI4-Lite SRAM
// Word array with byte write strobes, one response per request, answered
// one cycle after the request handshake

`timescale 1ns/1ps

module axil_sram #(
  parameter int unsigned SramWords = 1024
) (
  input  logic clk_i,
  input  logic rst_ni,
  axil_if.subordinate bus
);

  localparam int unsigned IdxWidth = $clog2(SramWords);

  typedef logic [IdxWidth-1:0] word_idx_t;

  axil_pkg::data_t mem_q [SramWords];
  axil_pkg::data_t r_data_q;
  logic            r_valid_q;
  logic            b_valid_q;

  word_idx_t rd_idx, wr_idx;
  logic      busy;
  logic      rd_hs, wr_hs;

  // ------------------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------------------
  // Nothing new is taken while a response is still pending
  assign busy = r_valid_q | b_valid_q;

  assign bus.ar_ready = bus.ar_valid & ~busy;
  assign bus.aw_ready = bus.aw_valid & bus.w_valid & ~bus.ar_valid & ~busy;
  assign bus.w_ready  = bus.aw_ready;

  assign rd_hs = bus.ar_valid & bus.ar_ready;
  assign wr_hs = bus.aw_valid & bus.aw_ready;

  // Word index sits above the byte offset, upper bits ignored
  assign rd_idx = bus.ar_addr[IdxWidth+1:2];
  assign wr_idx = bus.aw_addr[IdxWidth+1:2];

  // ------------------------------------------------------------------------
  // Response state
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (bus.r_ready) begin
        r_valid_q <= 1'b0;
      end
      if (wr_hs) begin
        b_valid_q <= 1'b1;
      end else if (bus.b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_data  = r_data_q;
  assign bus.r_resp  = axil_pkg::RESP_OKAY;
  assign bus.b_valid = b_valid_q;
  assign bus.b_resp  = axil_pkg::RESP_OKAY;

  // ------------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rd_hs) begin
      r_data_q <= mem_q[rd_idx];
    end
    if (wr_hs) begin
      for (int b = 0; b < axil_pkg::StrbWidth; b++) begin
        // Only the enabled byte lanes change
        if (bus.w_strb[b]) begin
          mem_q[wr_idx][8*b +: 8] <= bus.w_data[8*b +: 8];
        end
      end
    end
  end

endmodule

/* design/axil_decoder.sv */
// AXI4-Lite address decoder
// Takes one transaction at a time, registers it and forwards it to the
// boot ROM or the SRAM. Unmapped addresses get a DECERR response here.

`timescale 1ns/1ps

module axil_decoder #(
  parameter int unsigned SramWords = 1024
) (
  input  logic clk_i,
  input  logic rst_ni,
  axil_if.subordinate mgr,
  axil_if.manager     rom_bus,
  axil_if.manager     sram_bus
);

  localparam axil_pkg::addr_t SramLength = axil_pkg::addr_t'(SramWords * 4);

  typedef enum logic [1:0] {
    IDLE,
    FWD_REQ,
    WAIT_RSP,
    ERR_RSP
  } state_e;

  state_e                state_q, state_d;
  logic                  is_write_q;
  soc_cfg_pkg::target_e  target_q, target_d;
  axil_pkg::addr_t       addr_q;
  axil_pkg::data_t       wdata_q;
  axil_pkg::strb_t       wstrb_q;

  axil_pkg::addr_t       req_addr;
  logic                  rom_hit, sram_hit;
  logic                  rd_accept, wr_accept;
  logic                  fwd_rom, fwd_sram;
  logic                  wait_rom, wait_sram;
  logic                  tgt_req_done, rsp_done;

  // ------------------------------------------------------------------------
  // Request acceptance and address decode
  // ------------------------------------------------------------------------
  // Reads take priority when both arrive together
  assign rd_accept = (state_q == IDLE) & mgr.ar_valid;
  assign wr_accept = (state_q == IDLE) & ~mgr.ar_valid & mgr.aw_valid & mgr.w_valid;

  assign mgr.ar_ready = rd_accept;
  assign mgr.aw_ready = wr_accept;
  assign mgr.w_ready  = wr_accept;

  assign req_addr = mgr.ar_valid ? mgr.ar_addr : mgr.aw_addr;

  // Offset compare wraps below the base, so one test covers both bounds
  assign rom_hit  = (req_addr - soc_cfg_pkg::RomBase) < soc_cfg_pkg::RomLength;
  assign sram_hit = (req_addr - soc_cfg_pkg::SramBase) < SramLength;
  assign target_d = sram_hit ? soc_cfg_pkg::TGT_SRAM : soc_cfg_pkg::TGT_ROM;

  // ------------------------------------------------------------------------
  // Target side
  // ------------------------------------------------------------------------
  assign fwd_rom   = (state_q == FWD_REQ) & (target_q == soc_cfg_pkg::TGT_ROM);
  assign fwd_sram  = (state_q == FWD_REQ) & (target_q == soc_cfg_pkg::TGT_SRAM);
  assign wait_rom  = (state_q == WAIT_RSP) & (target_q == soc_cfg_pkg::TGT_ROM);
  assign wait_sram = (state_q == WAIT_RSP) & (target_q == soc_cfg_pkg::TGT_SRAM);

  assign rom_bus.ar_addr  = addr_q;
  assign rom_bus.ar_valid = fwd_rom & ~is_write_q;
  assign rom_bus.aw_addr  = addr_q;
  assign rom_bus.aw_valid = fwd_rom & is_write_q;
  assign rom_bus.w_data   = wdata_q;
  assign rom_bus.w_strb   = wstrb_q;
  assign rom_bus.w_valid  = fwd_rom & is_write_q;
  assign rom_bus.b_ready  = wait_rom & mgr.b_ready;
  assign rom_bus.r_ready  = wait_rom & mgr.r_ready;

  assign sram_bus.ar_addr  = addr_q;
  assign sram_bus.ar_valid = fwd_sram & ~is_write_q;
  assign sram_bus.aw_addr  = addr_q;
  assign sram_bus.aw_valid = fwd_sram & is_write_q;
  assign sram_bus.w_data   = wdata_q;
  assign sram_bus.w_strb   = wstrb_q;
  assign sram_bus.w_valid  = fwd_sram & is_write_q;
  assign sram_bus.b_ready  = wait_sram & mgr.b_ready;
  assign sram_bus.r_ready  = wait_sram & mgr.r_ready;

  // Targets raise awready and wready together
  assign tgt_req_done = is_write_q ?
      ((fwd_rom & rom_bus.aw_ready) | (fwd_sram & sram_bus.aw_ready)) :
      ((fwd_rom & rom_bus.ar_ready) | (fwd_sram & sram_bus.ar_ready));

  // ------------------------------------------------------------------------
  // Response path back to the manager
  // ------------------------------------------------------------------------
  always_comb begin
    mgr.b_valid = 1'b0;
    mgr.b_resp  = axil_pkg::RESP_OKAY;
    mgr.r_valid = 1'b0;
    mgr.r_data  = '0;
    mgr.r_resp  = axil_pkg::RESP_OKAY;
    if (wait_rom) begin
      mgr.b_valid = rom_bus.b_valid;
      mgr.b_resp  = rom_bus.b_resp;
      mgr.r_valid = rom_bus.r_valid;
      mgr.r_data  = rom_bus.r_data;
      mgr.r_resp  = rom_bus.r_resp;
    end else if (wait_sram) begin
      mgr.b_valid = sram_bus.b_valid;
      mgr.b_resp  = sram_bus.b_resp;
      mgr.r_valid = sram_bus.r_valid;
      mgr.r_data  = sram_bus.r_data;
      mgr.r_resp  = sram_bus.r_resp;
    end else if (state_q == ERR_RSP) begin
      // Unmapped, read data stays zero
      mgr.b_valid = is_write_q;
      mgr.b_resp  = axil_pkg::RESP_DECERR;
      mgr.r_valid = ~is_write_q;
      mgr.r_resp  = axil_pkg::RESP_DECERR;
    end
  end

  assign rsp_done = (mgr.b_valid & mgr.b_ready) | (mgr.r_valid & mgr.r_ready);

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (rd_accept || wr_accept) begin
          state_d = (rom_hit || sram_hit) ? FWD_REQ : ERR_RSP;
        end
      end
      FWD_REQ: begin
        if (tgt_req_done) state_d = WAIT_RSP;
      end
      WAIT_RSP, ERR_RSP: begin
        if (rsp_done) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      is_write_q <= 1'b0;
      target_q   <= soc_cfg_pkg::TGT_ROM;
    end else begin
      state_q <= state_d;
      if (rd_accept || wr_accept) begin
        is_write_q <= wr_accept;
        target_q   <= target_d;
      end
    end
  end

  // Captured request payload
  always_ff @(posedge clk_i) begin
    if (rd_accept || wr_accept) begin
      addr_q  <= req_addr;
      wdata_q <= mgr.w_data;
      wstrb_q <= mgr.w_strb;
    end
  end

endmodule

/* design/axil_if.sv */
// AXI4-Lite bus bundle
// Five channels with a manager view and a subordinate view

`timescale 1ns/1ps

interface axil_if;

  axil_pkg::addr_t aw_addr;
  logic            aw_valid;
  logic            aw_ready;

  axil_pkg::data_t w_data;
  axil_pkg::strb_t w_strb;
  logic            w_valid;
  logic            w_ready;

  axil_pkg::resp_e b_resp;
  logic            b_valid;
  logic            b_ready;

  axil_pkg::addr_t ar_addr;
  logic            ar_valid;
  logic            ar_ready;

  axil_pkg::data_t r_data;
  axil_pkg::resp_e r_resp;
  logic            r_valid;
  logic            r_ready;

  modport manager (
    output aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
    output ar_addr, ar_valid, r_ready,
    input  aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
  );

  modport subordinate (
    input  aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
    input  ar_addr, ar_valid, r_ready,
    output aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
  );

endinterface

/* design/soc_cfg_pkg.sv */
// Subsystem configuration
// Address map, target indices and the boot ROM image

package soc_cfg_pkg;

  // ------------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------------
  typedef enum logic {
    TGT_ROM  = 1'b0,
    TGT_SRAM = 1'b1
  } target_e;

  localparam axil_pkg::addr_t RomBase   = 32'h0001_0000;
  localparam axil_pkg::addr_t RomLength = 32'h0000_1000;
  // SRAM window length comes from the SramWords parameter
  localparam axil_pkg::addr_t SramBase  = 32'h8000_0000;

  // ------------------------------------------------------------------------
  // Boot ROM image
  // ------------------------------------------------------------------------
  localparam int RomWords = 8;

  // Hart id into a0, image pointer into a1, then jump to SRAM
  localparam axil_pkg::data_t BootRomImage [0:RomWords-1] = '{
    32'hf140_2573,  // csrr  a0, mhartid
    32'h0000_0597,  // auipc a1, 0
    32'h0105_8593,  // addi  a1, a1, 16
    32'h8000_02b7,  // lui   t0, 0x80000
    32'h0002_8067,  // jr    t0
    32'h1050_0073,  // wfi
    32'hffdf_f06f,  // j     -4
    32'h0000_0013   // nop
  };

endpackage

/* design/axil_pkg.sv */
// AXI4-Lite bus types
// Address, data and strobe widths plus the response encoding shared by
// every block on the bus

package axil_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Byte address on the bus
  typedef logic [AddrWidth-1:0] addr_t;
  // One bus word
  typedef logic [DataWidth-1:0] data_t;
  // One strobe bit per byte lane
  typedef logic [StrbWidth-1:0] strb_t;

  // ------------------------------------------------------------------------
  // Response codes
  // ------------------------------------------------------------------------
  // EXOKAY (2'b01) is not used on AXI4-Lite
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage
